/* Bender.yml */
package:
  name: gesture_perceptron

sources:
  - files:
      - blob_pkg.sv
      - perceptron_pkg.sv
      - blob_if.sv
      - shape_features.sv
      - motion_tracker.sv
      - gesture_hysteresis.sv
      - gesture_classifier.sv
      - gesture_perceptron.sv
  - target: test
    files:
      - tb_gesture_perceptron.sv

/* blob_if.sv */
`timescale 1ns/1ps

interface blob_if import blob_pkg::*; ();

    logic   valid;         // Blob present this frame
    coord_t cx;            // Centroid x
    coord_t min_x, max_x;  // Bounding box, x
    coord_t min_y, max_y;  // Bounding box, y
    area_t  area;          // Pixel count

    // Driven from the top-level pins
    modport source (output valid, cx, min_x, max_x, min_y, max_y, area);

    // Geometry only, no centroid
    modport shape (input valid, min_x, max_x, min_y, max_y, area);

    // Horizontal tracking
    modport motion (input valid, cx);

endinterface

/* blob_pkg.sv */
package blob_pkg;

    // ------------------------------------------------------------------
    // Blob statistic types
    // ------------------------------------------------------------------
    typedef logic [9:0]  coord_t;    // Pixel coordinate, 0..1023
    typedef logic [10:0] dim_t;      // Box width or height, needs the +1
    typedef logic [19:0] area_t;     // Blob pixel count
    typedef logic [21:0] box_area_t; // Width times height

    // ------------------------------------------------------------------
    // Geometry gate
    // ------------------------------------------------------------------
    // Smallest blob worth classifying
    localparam area_t MIN_AREA = 20'd200;

    // Both box sides must reach this
    localparam dim_t MIN_BOX_DIM = 11'd6;

    // Area feature clips to 255 above this count
    localparam area_t AREA_SAT = 20'd5000;

endpackage

/* filelist.f */
blob_pkg.sv
perceptron_pkg.sv
blob_if.sv
shape_features.sv
motion_tracker.sv
gesture_hysteresis.sv
gesture_classifier.sv
gesture_perceptron.sv
tb_gesture_perceptron.sv

/* gesture_classifier.sv */
`timescale 1ns/1ps

module gesture_classifier import perceptron_pkg::*; #(
    parameter int HYST_FRAMES = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     frame_start,
    input  logic     enable,
    input  feature_t compactness,
    input  feature_t area_feat,
    input  feature_t aspect,
    input  feature_t speed,
    input  feature_t oscillation,
    input  logic     qualified,
    output logic     fist,
    output logic     open_hand,
    output logic     wave,
    output feature_t debug_fist,
    output feature_t debug_open,
    output feature_t debug_wave
);

    feature_vec_u fv;
    activation_t  act_fist, act_open, act_wave;
    logic         raw_fist, raw_open, raw_wave;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    // Bias plus sum of w * f / 16, each term truncated toward zero
    function automatic activation_t weighted_sum(input feature_vec_u v,
                                                 input weight_t w [NUM_FEATURES],
                                                 input activation_t bias);
        activation_t       acc;
        logic signed [17:0] prod;
        acc = bias;
        for (int i = 0; i < NUM_FEATURES; i++) begin
            prod = w[i] * $signed({1'b0, v.feat[i]});
            acc  = acc + activation_t'(prod / 18'sd16);
        end
        return acc;
    endfunction

    // Clip to an unsigned byte
    function automatic feature_t clamp_byte(input activation_t a);
        if (a < 16'sd0) begin
            return 8'd0;
        end else if (a > 16'sd255) begin
            return 8'd255;
        end
        return a[7:0];
    endfunction

    // ------------------------------------------------------------------
    // Scoring
    // ------------------------------------------------------------------
    always_comb begin
        fv.field.compactness = compactness;
        fv.field.speed       = speed;
        fv.field.area        = area_feat;
        fv.field.aspect      = aspect;
        fv.field.oscillation = oscillation;
    end

    assign act_fist = weighted_sum(fv, W_FIST, B_FIST);
    assign act_open = weighted_sum(fv, W_OPEN, B_OPEN);
    assign act_wave = weighted_sum(fv, W_WAVE, B_WAVE);

    assign debug_fist = clamp_byte(act_fist);
    assign debug_open = clamp_byte(act_open);
    assign debug_wave = clamp_byte(act_wave);

    // Strict winner, above threshold, size gate passed
    assign raw_fist = qualified && (act_fist > act_open) && (act_fist > act_wave) &&
                      (act_fist > ACT_THRESHOLD);
    assign raw_open = qualified && (act_open > act_fist) && (act_open > act_wave) &&
                      (act_open > ACT_THRESHOLD);
    assign raw_wave = qualified && (act_wave > act_fist) && (act_wave > act_open) &&
                      (act_wave > ACT_THRESHOLD);

    gesture_hysteresis #(
        .HYST_FRAMES (HYST_FRAMES)
    ) u_hyst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .enable      (enable),
        .raw_fist    (raw_fist),
        .raw_open    (raw_open),
        .raw_wave    (raw_wave),
        .fist        (fist),
        .open_hand   (open_hand),
        .wave        (wave)
    );

    raw_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        frame_start |-> $onehot0({raw_fist, raw_open, raw_wave}))
        else $error("gesture_classifier: more than one raw class");

endmodule

/* gesture_hysteresis.sv */
`timescale 1ns/1ps

module gesture_hysteresis #(
    parameter int HYST_FRAMES = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic frame_start,
    input  logic enable,
    input  logic raw_fist,
    input  logic raw_open,
    input  logic raw_wave,
    output logic fist,
    output logic open_hand,
    output logic wave
);

    // Counter has to hold HYST_FRAMES itself
    localparam int CW = (HYST_FRAMES < 1) ? 1 : $clog2(HYST_FRAMES + 1);

    logic [2:0]    raw_vec;   // Bit 0 fist, 1 open, 2 wave
    logic [2:0]    out_q;
    logic [CW-1:0] count_q [3];

    assign raw_vec = {raw_wave, raw_open, raw_fist};

    // ------------------------------------------------------------------
    // Per-class frame counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q   <= '0;
            count_q <= '{default: '0};
        end else if (frame_start && enable) begin
            for (int c = 0; c < 3; c++) begin
                if (!raw_vec[c]) begin
                    count_q[c] <= '0;    // Any miss restarts
                    out_q[c]   <= 1'b0;
                end else if (count_q[c] < CW'(HYST_FRAMES)) begin
                    count_q[c] <= count_q[c] + 1'b1;
                end else begin
                    out_q[c] <= 1'b1;    // Held long enough
                end
            end
        end
    end

    assign fist      = out_q[0];
    assign open_hand = out_q[1];
    assign wave      = out_q[2];

    out_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(out_q))
        else $error("gesture_hysteresis: two gestures at once");

endmodule

/* gesture_perceptron.sv */
`timescale 1ns/1ps

module gesture_perceptron import blob_pkg::*, perceptron_pkg::*; #(
    parameter int HYST_FRAMES    = 2,  // Extra frames a class must hold
    parameter int MOVE_THRESHOLD = 2   // Pixels per frame that count as motion
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       frame_start,     // One-cycle strobe, blob stats stable
    input  logic       centroid_valid,
    input  coord_t     centroid_x,
    input  coord_t     bbox_min_x,
    input  coord_t     bbox_min_y,
    input  coord_t     bbox_max_x,
    input  coord_t     bbox_max_y,
    input  area_t      blob_area,
    output logic       fist,
    output logic       open_hand,
    output logic       wave,
    output logic [7:0] debug_activation_fist,
    output logic [7:0] debug_activation_open,
    output logic [7:0] debug_activation_wave
);

    feature_t compactness, area_feat, aspect;
    feature_t speed, oscillation;
    logic     qualified;

    // ------------------------------------------------------------------
    // Blob bundle, source side
    // ------------------------------------------------------------------
    blob_if blob ();

    assign blob.valid = centroid_valid;
    assign blob.cx    = centroid_x;
    assign blob.min_x = bbox_min_x;
    assign blob.max_x = bbox_max_x;
    assign blob.min_y = bbox_min_y;
    assign blob.max_y = bbox_max_y;
    assign blob.area  = blob_area;

    shape_features u_shape (
        .blob        (blob),
        .compactness (compactness),
        .area_feat   (area_feat),
        .aspect      (aspect),
        .qualified   (qualified)
    );

    motion_tracker #(
        .MOVE_THRESHOLD (MOVE_THRESHOLD)
    ) u_motion (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .blob        (blob),
        .speed       (speed),
        .oscillation (oscillation)
    );

    gesture_classifier #(
        .HYST_FRAMES (HYST_FRAMES)
    ) u_classifier (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .enable      (enable),
        .compactness (compactness),
        .area_feat   (area_feat),
        .aspect      (aspect),
        .speed       (speed),
        .oscillation (oscillation),
        .qualified   (qualified),
        .fist        (fist),
        .open_hand   (open_hand),
        .wave        (wave),
        .debug_fist  (debug_activation_fist),
        .debug_open  (debug_activation_open),
        .debug_wave  (debug_activation_wave)
    );

endmodule

/* motion_tracker.sv */
`timescale 1ns/1ps

module motion_tracker import blob_pkg::*, perceptron_pkg::*; #(
    parameter int MOVE_THRESHOLD = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     frame_start,
    blob_if.motion   blob,
    output feature_t speed,
    output feature_t oscillation
);

    coord_t             prev_x_q;     // Centroid x of last valid frame
    logic signed [10:0] velocity_q;   // Last x step, signed
    logic               dir_q;        // Recorded direction, 1 = right
    logic               dir_valid_q;  // A direction has been seen
    logic [2:0]         changes_q;    // Saturating reversal count
    logic [10:0]        abs_vel;
    logic               cur_dir;
    logic               update;

    assign update  = frame_start && blob.valid;
    assign abs_vel = velocity_q[10] ? 11'(-velocity_q) : 11'(velocity_q);
    assign cur_dir = ~velocity_q[10];

    // ------------------------------------------------------------------
    // Per-frame state
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_x_q    <= '0;
            velocity_q  <= '0;
            dir_q       <= 1'b0;
            dir_valid_q <= 1'b0;
            changes_q   <= '0;
        end else if (update) begin
            velocity_q <= $signed({1'b0, blob.cx}) - $signed({1'b0, prev_x_q});
            prev_x_q   <= blob.cx;

            // Judged on the old velocity, before the overwrite
            if (abs_vel > 11'(MOVE_THRESHOLD)) begin
                if (!dir_valid_q) begin
                    dir_q       <= cur_dir;  // First move only recorded
                    dir_valid_q <= 1'b1;
                end else if (cur_dir != dir_q) begin
                    dir_q <= cur_dir;
                    if (changes_q != 3'd7) begin
                        changes_q <= changes_q + 3'd1;
                    end
                end
            end else if (changes_q != 3'd0) begin
                changes_q <= changes_q - 3'd1;  // Hand at rest, decay
            end
        end
    end

    assign speed       = abs_vel[7:0];
    assign oscillation = {1'b0, changes_q, 4'd0};  // Count x 16

    // Count steps by at most one per frame and never wraps past 7
    change_step: assert property (@(posedge clk) disable iff (!rst_n)
        ({1'b0, changes_q} == {1'b0, $past(changes_q)}) ||
        ($past(update) && {1'b0, changes_q} == {1'b0, $past(changes_q)} + 4'd1) ||
        ($past(update) && {1'b0, changes_q} + 4'd1 == {1'b0, $past(changes_q)}))
        else $error("motion_tracker: change count jumped");

endmodule

/* perceptron_pkg.sv */
package perceptron_pkg;

    localparam int NUM_FEATURES = 5;

    // ------------------------------------------------------------------
    // Feature vector
    // ------------------------------------------------------------------
    typedef logic [7:0] feature_t;  // Unsigned feature byte

    // Field order matches index order of the array view below
    typedef struct packed {
        feature_t compactness;  // Index 0
        feature_t speed;        // Index 1
        feature_t area;         // Index 2
        feature_t aspect;       // Index 3
        feature_t oscillation;  // Index 4
    } feature_fields_t;

    // Producers fill by name, the weighted sums walk the array
    typedef union packed {
        feature_t [0:NUM_FEATURES-1] feat;
        feature_fields_t             field;
    } feature_vec_u;

    // ------------------------------------------------------------------
    // Perceptron constants
    // ------------------------------------------------------------------
    typedef logic signed [8:0]  weight_t;
    typedef logic signed [15:0] activation_t;

    // Fist likes compact, still blobs
    localparam weight_t W_FIST [NUM_FEATURES] = '{
        9'sd100, -9'sd20, 9'sd30, 9'sd10, -9'sd50
    };

    // Open hand likes sparse, large blobs
    localparam weight_t W_OPEN [NUM_FEATURES] = '{
        -9'sd80, -9'sd20, 9'sd50, 9'sd20, -9'sd50
    };

    // Wave is mostly speed and oscillation
    localparam weight_t W_WAVE [NUM_FEATURES] = '{
        9'sd20, 9'sd100, 9'sd20, 9'sd10, 9'sd120
    };

    localparam activation_t B_FIST = -16'sd50;
    localparam activation_t B_OPEN = -16'sd30;
    localparam activation_t B_WAVE = -16'sd60;

    localparam activation_t ACT_THRESHOLD = 16'sd128;  // Winner must beat this

endpackage

/* shape_features.sv */
`timescale 1ns/1ps

module shape_features import blob_pkg::*, perceptron_pkg::*; (
    blob_if.shape    blob,
    output feature_t compactness,
    output feature_t area_feat,
    output feature_t aspect,
    output logic     qualified
);

    dim_t        width;
    dim_t        height;
    box_area_t   box_area;
    box_area_t   divisor;
    logic [27:0] ratio;  // Area * 256 / box area before clipping

    // ------------------------------------------------------------------
    // Box geometry
    // ------------------------------------------------------------------
    always_comb begin
        // Inverted or missing box gives zero size
        width  = (blob.valid && blob.max_x >= blob.min_x) ?
                 ({1'b0, blob.max_x} - {1'b0, blob.min_x} + 11'd1) : 11'd0;
        height = (blob.valid && blob.max_y >= blob.min_y) ?
                 ({1'b0, blob.max_y} - {1'b0, blob.min_y} + 11'd1) : 11'd0;
        box_area = width * height;  // 11 x 11 fits in 22
    end

    // ------------------------------------------------------------------
    // Compactness as an exact ratio
    // ------------------------------------------------------------------
    assign divisor = (box_area == '0) ? 22'd1 : box_area;  // Keep divider defined
    assign ratio   = {blob.area, 8'd0} / divisor;

    always_comb begin
        if (box_area == '0) begin
            compactness = 8'd0;    // Also covers a missing blob
        end else if (ratio > 28'd255) begin
            compactness = 8'd255;  // Blob denser than its box from noisy stats
        end else begin
            compactness = ratio[7:0];
        end
    end

    // Coarse area as area / 32
    assign area_feat = (blob.area > AREA_SAT) ? 8'd255 : blob.area[12:5];

    // Three-level aspect class
    always_comb begin
        if (height == '0) begin
            aspect = 8'd128;
        end else if (width > height) begin
            aspect = 8'd200;  // Wide
        end else if (width < height) begin
            aspect = 8'd50;   // Tall
        end else begin
            aspect = 8'd128;  // Square
        end
    end

    // Size gate for the classifier
    assign qualified = blob.valid && (blob.area >= MIN_AREA) &&
                       (width >= MIN_BOX_DIM) && (height >= MIN_BOX_DIM);

    // No blob means no density
    valid_low_clears: assert final (blob.valid || compactness == 8'd0)
        else $error("shape_features: compactness nonzero without valid blob");

endmodule

/* tb_gesture_perceptron.sv */
`timescale 1ns/1ps

module tb_gesture_perceptron;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_CYCLES = 2;   // Drive cycle then strobe cycle
    localparam int HYST         = 2;
    localparam int MOVE_THR     = 2;
    localparam int RAND_FRAMES  = 48;
    localparam int TOTAL_FRAMES = 2 + 5 + 6 + 24 + 4 + RAND_FRAMES;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic        frame_start;
    logic        centroid_valid;
    logic [9:0]  centroid_x;
    logic [9:0]  bbox_min_x, bbox_min_y, bbox_max_x, bbox_max_y;
    logic [19:0] blob_area;
    logic        fist, open_hand, wave;
    logic [7:0]  debug_activation_fist, debug_activation_open, debug_activation_wave;

    // Rows fist, open, wave; columns compactness, speed, area, aspect, oscillation
    int w_tab [3][5] = '{'{100, -20, 30, 10, -50},
                         '{-80, -20, 50, 20, -50},
                         '{20, 100, 20, 10, 120}};
    int bias_tab [3] = '{-50, -30, -60};

    int m_prev_x, m_vel, m_dir, m_dir_valid, m_changes;  // Model motion state
    int m_count [3];
    int m_out [3];
    int e_act [3];   // Expected activations of the current frame
    int e_raw [3];
    int err_count;
    int unsigned lcg_state;

    gesture_perceptron #(
        .HYST_FRAMES    (HYST),
        .MOVE_THRESHOLD (MOVE_THR)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;  // Upper bits only
    endfunction

    function automatic int clamp_byte(input int a);
        return (a < 0) ? 0 : ((a > 255) ? 255 : a);
    endfunction

    task automatic eval_model();
        int w;
        int h;
        int box;
        int a;
        int q;
        int f [5];
        a = int'(blob_area);
        w = (centroid_valid && bbox_max_x >= bbox_min_x) ?
            int'(bbox_max_x) - int'(bbox_min_x) + 1 : 0;
        h = (centroid_valid && bbox_max_y >= bbox_min_y) ?
            int'(bbox_max_y) - int'(bbox_min_y) + 1 : 0;
        box = w * h;
        f[0] = (!centroid_valid || box == 0) ? 0 : (a * 256) / box;
        if (f[0] > 255) f[0] = 255;
        f[1] = ((m_vel < 0) ? -m_vel : m_vel) % 256;
        f[2] = (a > 5000) ? 255 : (a / 32) % 256;
        if (h == 0 || w == h) f[3] = 128;
        else f[3] = (w > h) ? 200 : 50;
        f[4] = m_changes * 16;
        q = centroid_valid && a >= 200 && w >= 6 && h >= 6;
        for (int c = 0; c < 3; c++) begin
            e_act[c] = bias_tab[c];
            for (int i = 0; i < 5; i++) begin
                e_act[c] += (w_tab[c][i] * f[i]) / 16;  // Truncates toward zero
            end
        end
        for (int c = 0; c < 3; c++) begin
            e_raw[c] = q && e_act[c] > e_act[(c + 1) % 3] && e_act[c] > e_act[(c + 2) % 3]
                       && e_act[c] > 128;
        end
    endtask

    // Strobe edge updates hysteresis from this frame's raw classes, then motion
    task automatic advance_model();
        int dir;
        for (int c = 0; c < 3; c++) begin
            if (enable) begin
                if (!e_raw[c]) begin
                    m_count[c] = 0;
                    m_out[c]   = 0;
                end else if (m_count[c] < HYST) begin
                    m_count[c]++;
                end else begin
                    m_out[c] = 1;
                end
            end
        end
        if (centroid_valid) begin
            if (((m_vel < 0) ? -m_vel : m_vel) > MOVE_THR) begin
                dir = (m_vel > 0);
                if (!m_dir_valid) begin
                    m_dir       = dir;  // First move just recorded
                    m_dir_valid = 1;
                end else if (dir != m_dir) begin
                    m_dir = dir;
                    if (m_changes < 7) m_changes++;
                end
            end else if (m_changes > 0) begin
                m_changes--;
            end
            m_vel    = int'(centroid_x) - m_prev_x;
            m_prev_x = int'(centroid_x);
        end
    endtask

    // ------------------------------------------------------------------
    // Checking and frame driving
    // ------------------------------------------------------------------
    task automatic report_mismatch(input string what, input int got, input int expected);
        err_count++;
        $display("error: time %0t: %s is %0d, expected %0d", $time, what, got, expected);
        $display("Errors found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic expect_level(input string what, input logic got, input logic expected);
        assert (got === expected) else report_mismatch(what, int'(got), int'(expected));
    endtask

    task automatic check_debug();
        assert (debug_activation_fist === 8'(clamp_byte(e_act[0])))
            else report_mismatch("debug fist", debug_activation_fist, clamp_byte(e_act[0]));
        assert (debug_activation_open === 8'(clamp_byte(e_act[1])))
            else report_mismatch("debug open", debug_activation_open, clamp_byte(e_act[1]));
        assert (debug_activation_wave === 8'(clamp_byte(e_act[2])))
            else report_mismatch("debug wave", debug_activation_wave, clamp_byte(e_act[2]));
    endtask

    task automatic compare_outputs();
        expect_level("fist", fist, m_out[0] != 0);
        expect_level("open_hand", open_hand, m_out[1] != 0);
        expect_level("wave", wave, m_out[2] != 0);
    endtask

    // One frame of stable stats, one-cycle strobe and model step
    task automatic run_frame(input int v, input int cx, input int x0, input int x1,
                             input int y0, input int y1, input int ar);
        @(posedge clk);
        centroid_valid <= (v != 0);
        centroid_x     <= 10'(cx);
        bbox_min_x     <= 10'(x0);
        bbox_max_x     <= 10'(x1);
        bbox_min_y     <= 10'(y0);
        bbox_max_y     <= 10'(y1);
        blob_area      <= 20'(ar);
        frame_start    <= 1'b1;
        @(negedge clk);
        eval_model();
        check_debug();      // Sampled before the strobe edge
        @(posedge clk);
        frame_start <= 1'b0;
        advance_model();
        @(negedge clk);
        compare_outputs();
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic reset_state();
        compare_outputs();
        for (int n = 0; n < 2; n++) begin
            run_frame(0, 0, 0, 0, 0, 0, 0);
        end
        // Only aspect is nonzero with no blob
        assert (debug_activation_fist === 8'd30)
            else report_mismatch("idle debug fist", debug_activation_fist, 30);
        assert (debug_activation_open === 8'd130)
            else report_mismatch("idle debug open", debug_activation_open, 130);
        assert (debug_activation_wave === 8'd20)
            else report_mismatch("idle debug wave", debug_activation_wave, 20);
    endtask

    task automatic fist_hold();
        for (int n = 1; n <= 5; n++) begin
            run_frame(1, 300, 280, 319, 280, 319, 1600);  // Full 40x40 box
            expect_level("fist rise", fist, n >= HYST + 1);
            expect_level("open_hand during fist", open_hand, 1'b0);
            expect_level("wave during fist", wave, 1'b0);
        end
    endtask

    task automatic open_hand_hold();
        for (int n = 1; n <= 5; n++) begin
            run_frame(1, 300, 100, 399, 100, 399, 4800);  // Sparse 300x300
            expect_level("open_hand rise", open_hand, n >= HYST + 1);
            expect_level("fist during open", fist, 1'b0);
        end
        run_frame(1, 300, 100, 399, 100, 399, 100);  // Below MIN_AREA
        expect_level("open_hand release", open_hand, 1'b0);
    endtask

    task automatic wave_and_rest();
        for (int k = 1; k <= 12; k++) begin
            run_frame(1, (k % 2) ? 320 : 300, 270, 329, 270, 329, 900);
        end
        expect_level("wave after motion", wave, 1'b1);
        for (int k = 1; k <= 12; k++) begin
            run_frame(1, 300, 270, 329, 270, 329, 900);  // Hand at rest
        end
        expect_level("wave after rest", wave, 1'b0);
    endtask

    task automatic enable_low_hold();
        logic [2:0] held;
        held = {wave, open_hand, fist};
        @(posedge clk);
        enable <= 1'b0;
        run_frame(1, 300, 100, 399, 100, 399, 4800);
        run_frame(1, 310, 280, 319, 280, 319, 1600);
        run_frame(1, 340, 280, 319, 280, 319, 150);
        run_frame(0, 0, 0, 0, 0, 0, 0);
        assert ({wave, open_hand, fist} === held)
            else report_mismatch("outputs with enable low", {wave, open_hand, fist}, held);
        @(posedge clk);
        enable <= 1'b1;
    endtask

    task automatic random_frames();
        int v, x0, x1, y0, y1, cx, ar, t;
        for (int n = 0; n < RAND_FRAMES; n++) begin
            v  = (lcg_next() % 8) != 0;
            x0 = lcg_next() % 700;
            x1 = x0 + lcg_next() % 300;
            y0 = lcg_next() % 700;
            y1 = y0 + lcg_next() % 300;
            cx = x0 + lcg_next() % (x1 - x0 + 1);
            ar = (x1 - x0 + 1) * (y1 - y0 + 1) * (lcg_next() % 300) / 256;
            if (lcg_next() % 16 == 0) begin
                t  = x0;  // Inverted box now and then
                x0 = x1;
                x1 = t;
            end
            run_frame(v, cx, x0, x1, y0, y1, ar);
        end
    endtask

    initial begin
        #((RESET_CYCLES + TOTAL_FRAMES * FRAME_CYCLES + 20) * CLK_PERIOD * 2);
        $display("timeout: the tests did not finish in the expected time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        lcg_state      = 6;
        err_count      = 0;
        rst_n          = 1'b0;
        enable         = 1'b1;
        frame_start    = 1'b0;
        centroid_valid = 1'b0;
        centroid_x     = '0;
        bbox_min_x     = '0;
        bbox_max_x     = '0;
        bbox_min_y     = '0;
        bbox_max_y     = '0;
        blob_area      = '0;
        m_prev_x       = 0;
        m_vel          = 0;
        m_dir          = 0;
        m_dir_valid    = 0;
        m_changes      = 0;
        m_count        = '{0, 0, 0};
        m_out          = '{0, 0, 0};
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        fist_hold();
        open_hand_hold();
        wave_and_rest();
        enable_low_hold();
        random_frames();
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
